//--- logic/axis_skid.sv
// two-entry output stage for the payload stream
// an output register plus a temporary register that catches the
// beat already in flight when the sink stalls
`timescale 1ns/10ps

module axis_skid
  import roce_tx_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  axis_beat_t in_beat,
  input  logic       in_valid,
  output logic       room,
  output axis_beat_t m_pay,
  output logic       m_pay_valid,
  input  logic       m_pay_ready
);

  axis_beat_t out_q;
  axis_beat_t temp_q;
  logic       out_valid_q;
  logic       temp_valid_q;
  logic       load_out;
  logic       load_temp;
  logic       temp_to_out;

  // early ready from the stored state, upstream registers it
  assign room = m_pay_ready || (!out_valid_q && !temp_valid_q);

  assign m_pay = out_q;
  assign m_pay_valid = out_valid_q;

  always_comb begin
    load_out = 1'b0;
    load_temp = 1'b0;
    temp_to_out = 1'b0;
    if (in_valid) begin
      if (m_pay_ready || !out_valid_q) begin
        load_out = 1'b1;
      end else begin
        load_temp = 1'b1;
      end
    end else if (m_pay_ready) begin
      temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
      temp_valid_q <= 1'b0;
    end else begin
      if (load_out) begin
        out_valid_q <= 1'b1;
      end else if (temp_to_out) begin
        out_valid_q <= temp_valid_q;
        temp_valid_q <= 1'b0;
      end
      if (load_temp) begin
        temp_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) begin
      out_q <= in_beat;
    end else if (temp_to_out) begin
      out_q <= temp_q;
    end
    if (load_temp) begin
      temp_q <= in_beat;
    end
  end

endmodule

//--- logic/payload_realign.sv
// half-word payload realigner
// keeps the upper half of the previous beat and joins it with the
// lower half of the current one; a last beat with bytes in its
// upper half is followed by one extra flush beat
`timescale 1ns/10ps

module payload_realign
  import roce_tx_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  axis_beat_t s_pay,
  input  logic       shift_take,
  input  logic       shift_flush,
  output axis_beat_t shift_beat,
  output logic       shift_valid,
  output logic       shift_can_take
);

  logic [63:0] save_data;
  logic [7:0]  save_keep;
  logic        save_user;
  logic        save_last_q;
  // saved upper half still owes a beat
  logic        extra_q;
  logic        upper_used;

  assign upper_used = keep_count(s_pay.keep) > 4'd4;

  always_comb begin
    shift_beat.data[31:0] = save_data[63:32];
    shift_beat.keep[3:0] = save_keep[7:4];
    if (extra_q) begin
      shift_beat.data[63:32] = 32'h0;
      shift_beat.keep[7:4] = 4'h0;
      shift_beat.last = save_last_q;
      shift_beat.user = save_user;
    end else begin
      shift_beat.data[63:32] = s_pay.data[31:0];
      shift_beat.keep[7:4] = s_pay.keep[3:0];
      // end only here when nothing spills into the next beat
      shift_beat.last = s_pay.last && !upper_used;
      shift_beat.user = s_pay.user && !upper_used;
    end
  end

  assign shift_valid = extra_q || shift_take;
  assign shift_can_take = !(shift_take && s_pay.last) && !save_last_q;

  always_ff @(posedge clk) begin
    if (rst || shift_flush) begin
      save_last_q <= 1'b0;
      extra_q <= 1'b0;
    end else if (shift_take) begin
      save_last_q <= s_pay.last;
      extra_q <= s_pay.last && upper_used;
    end
  end

  always_ff @(posedge clk) begin
    if (shift_take) begin
      save_data <= s_pay.data;
      save_keep <= s_pay.keep;
      save_user <= s_pay.user;
    end
  end

endmodule

//--- logic/roce_hdr_words.sv
// request capture and header serializer
// holds one request, presents the output network header with the
// IP length filled in, and lays out BTH and RETH as 64-bit words
// in network byte order, byte 0 in the low lane
`timescale 1ns/10ps

module roce_hdr_words
  import roce_tx_pkg::*;
(
  input  logic          clk,
  input  tx_req_t       s_req,
  input  logic          hdr_load,
  input  hdr_word_sel_t word_sel,
  output net_hdr_t      m_hdr,
  output logic [63:0]   hdr_word,
  output logic          has_reth,
  output logic          last_hdr_word
);

  localparam hdr_word_sel_t LAST_BTH = hdr_word_sel_t'(BTH_BYTES / WORD_BYTES);
  localparam hdr_word_sel_t LAST_RETH =
    hdr_word_sel_t'((BTH_BYTES + RETH_BYTES) / WORD_BYTES);

  tx_req_t req_q;

  // big-endian 32-bit field onto four byte lanes
  function automatic logic [31:0] swap32(input logic [31:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
  endfunction

  always_ff @(posedge clk) begin
    if (hdr_load) begin
      req_q <= s_req;
      req_q.net.ip_length <= s_req.net.udp_length + 16'(IP_HDR_BYTES);
    end
  end

  assign m_hdr = req_q.net;
  assign has_reth = req_q.has_reth;
  assign last_hdr_word = (word_sel == (req_q.has_reth ? LAST_RETH : LAST_BTH));

  always_comb begin
    case (word_sel)
      2'd0: begin
        // opcode, zero SE/M/pad/tver, p_key, reserved, dest QP
        hdr_word = {req_q.bth.dest_qp[7:0], req_q.bth.dest_qp[15:8],
                    req_q.bth.dest_qp[23:16], 8'h00,
                    req_q.bth.p_key[7:0], req_q.bth.p_key[15:8],
                    8'h00, req_q.bth.opcode};
      end
      2'd1: begin
        // ack bit on top of byte 8 and PSN, then the top of the virtual address if present
        hdr_word[31:0] = {req_q.bth.psn[7:0], req_q.bth.psn[15:8],
                          req_q.bth.psn[23:16], req_q.bth.ack_req, 7'b0};
        hdr_word[63:32] = req_q.has_reth ? swap32(req_q.reth.v_addr[63:32]) : 32'h0;
      end
      2'd2: begin
        hdr_word = {swap32(req_q.reth.r_key), swap32(req_q.reth.v_addr[31:0])};
      end
      default: begin
        // half word, upper lanes filled with payload
        hdr_word = {32'h0, swap32(req_q.reth.dma_len)};
      end
    endcase
  end

endmodule

//--- logic/roce_tx_ctrl.sv
// packet controller for the roce transmit path
// accepts one request per packet, steps through the header words,
// merges the final half header word with the first shifted payload
// half and then streams the realigned payload into the skid buffer
`timescale 1ns/10ps

module roce_tx_ctrl
  import roce_tx_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          s_req_valid,
  output logic          s_req_ready,
  input  logic          has_reth,
  input  logic          s_pay_valid,
  output logic          s_pay_ready,
  input  logic          m_hdr_ready,
  output logic          m_hdr_valid,
  output logic          hdr_load,
  output hdr_word_sel_t word_sel,
  input  logic [63:0]   hdr_word,
  input  logic          last_hdr_word,
  input  axis_beat_t    shift_beat,
  input  logic          shift_valid,
  input  logic          shift_can_take,
  output logic          shift_take,
  output logic          shift_flush,
  input  logic          room,
  output axis_beat_t    in_beat,
  output logic          in_valid,
  output logic          busy
);

  typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_HDR_LAST, ST_PAY} state_t;

  state_t        state;
  state_t        state_next;
  hdr_word_sel_t word_next;
  logic          req_ready_next;
  logic          pay_ready_next;
  logic          hdr_valid_next;
  // skid can take a beat this cycle
  logic          out_ok;
  logic          next_is_last;

  assign shift_take = s_pay_valid && s_pay_ready;

  // word 1 is the half word for BTH only, word 3 with RETH
  assign next_is_last = has_reth ? (word_sel == 2'd2) : (word_sel == 2'd0);

  always_comb begin
    state_next = state;
    word_next = word_sel;
    req_ready_next = 1'b0;
    pay_ready_next = 1'b0;
    hdr_valid_next = m_hdr_valid && !m_hdr_ready;
    hdr_load = 1'b0;
    shift_flush = 1'b0;
    in_valid = 1'b0;
    in_beat = shift_beat;

    case (state)
      ST_IDLE: begin
        shift_flush = 1'b1;
        word_next = '0;
        // hold off a new request while the last header waits
        req_ready_next = !hdr_valid_next;
        if (s_req_valid && s_req_ready) begin
          hdr_load = 1'b1;
          hdr_valid_next = 1'b1;
          req_ready_next = 1'b0;
          state_next = ST_HDR;
        end
      end
      ST_HDR: begin
        in_beat.data = hdr_word;
        in_beat.keep = 8'hff;
        in_beat.last = 1'b0;
        in_beat.user = 1'b0;
        if (out_ok) begin
          in_valid = 1'b1;
          word_next = word_sel + 2'd1;
          if (next_is_last) begin
            // open the payload side one cycle ahead of the merge
            pay_ready_next = room && shift_can_take;
            state_next = ST_HDR_LAST;
          end
        end
      end
      ST_HDR_LAST: begin
        pay_ready_next = room && shift_can_take;
        in_beat.data = {shift_beat.data[63:32], hdr_word[31:0]};
        in_beat.keep = {shift_beat.keep[7:4], {4{last_hdr_word}}};
        if (shift_take) begin
          in_valid = 1'b1;
          if (shift_beat.last) begin
            req_ready_next = !hdr_valid_next;
            state_next = ST_IDLE;
          end else begin
            state_next = ST_PAY;
          end
        end
      end
      default: begin
        pay_ready_next = room && shift_can_take;
        // shift_valid covers both a taken beat and the flush beat
        if (out_ok && shift_valid) begin
          in_valid = 1'b1;
          if (shift_beat.last) begin
            req_ready_next = !hdr_valid_next;
            state_next = ST_IDLE;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      word_sel <= '0;
      s_req_ready <= 1'b0;
      s_pay_ready <= 1'b0;
      m_hdr_valid <= 1'b0;
      out_ok <= 1'b0;
      busy <= 1'b0;
    end else begin
      state <= state_next;
      word_sel <= word_next;
      s_req_ready <= req_ready_next;
      s_pay_ready <= pay_ready_next;
      m_hdr_valid <= hdr_valid_next;
      out_ok <= room;
      busy <= (state_next != ST_IDLE);
    end
  end

endmodule

//--- logic/roce_tx_pkg.sv
// roce v2 transmit package
// stream beat, BTH/RETH and network header types, header sizes
// and keep mask helpers shared by the header inserter
package roce_tx_pkg;

  localparam int BTH_BYTES = 12;
  localparam int RETH_BYTES = 16;
  localparam int IP_HDR_BYTES = 20;
  localparam int WORD_BYTES = 8;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  keep;
    logic        last;
    logic        user;
  } axis_beat_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [15:0] p_key;
    logic [23:0] psn;
    logic [23:0] dest_qp;
    logic        ack_req;
  } bth_t;

  typedef struct packed {
    logic [63:0] v_addr;
    logic [31:0] r_key;
    logic [31:0] dma_len;
  } reth_t;

  // ip_length is ignored on input and filled in on output
  typedef struct packed {
    logic [47:0] eth_dest_mac;
    logic [47:0] eth_src_mac;
    logic [15:0] eth_type;
    logic [3:0]  ip_version;
    logic [3:0]  ip_ihl;
    logic [5:0]  ip_dscp;
    logic [1:0]  ip_ecn;
    logic [15:0] ip_identification;
    logic [2:0]  ip_flags;
    logic [12:0] ip_fragment_offset;
    logic [7:0]  ip_ttl;
    logic [7:0]  ip_protocol;
    logic [15:0] ip_header_checksum;
    logic [31:0] ip_source_ip;
    logic [31:0] ip_dest_ip;
    logic [15:0] udp_source_port;
    logic [15:0] udp_dest_port;
    logic [15:0] udp_length;
    logic [15:0] udp_checksum;
    logic [15:0] ip_length;
  } net_hdr_t;

  typedef struct packed {
    net_hdr_t net;
    bth_t     bth;
    reth_t    reth;
    logic     has_reth;
  } tx_req_t;

  typedef logic [1:0] hdr_word_sel_t;

  // byte count of a contiguous low-aligned keep mask
  function automatic logic [3:0] keep_count(input logic [7:0] keep);
    logic [3:0] n;
    n = 4'd0;
    for (int i = 0; i < 8; i++) begin
      if (keep[i]) begin
        n = 4'(i + 1);
      end
    end
    return n;
  endfunction

  function automatic logic [7:0] count_keep(input logic [3:0] count);
    if (count >= 4'd8) begin
      return 8'hff;
    end
    return 8'hff >> (4'd8 - count);
  endfunction

endpackage

//--- logic/roce_tx_top.sv
// roce v2 transmit header inserter
// prepends BTH and optional RETH to a 64-bit payload stream,
// realigns the payload by half a word and forwards the
// network header with the IP length filled in
`timescale 1ns/10ps

module roce_tx_top
  import roce_tx_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  tx_req_t    s_req,
  input  logic       s_req_valid,
  output logic       s_req_ready,
  input  axis_beat_t s_pay,
  input  logic       s_pay_valid,
  output logic       s_pay_ready,
  output net_hdr_t   m_hdr,
  output logic       m_hdr_valid,
  input  logic       m_hdr_ready,
  output axis_beat_t m_pay,
  output logic       m_pay_valid,
  input  logic       m_pay_ready,
  output logic       busy
);

  logic          has_reth;
  logic          hdr_load;
  hdr_word_sel_t word_sel;
  logic [63:0]   hdr_word;
  logic          last_hdr_word;
  axis_beat_t    shift_beat;
  logic          shift_valid;
  logic          shift_can_take;
  logic          shift_take;
  logic          shift_flush;
  logic          room;
  axis_beat_t    in_beat;
  logic          in_valid;

  roce_tx_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .s_req_valid    (s_req_valid),
    .s_req_ready    (s_req_ready),
    .has_reth       (has_reth),
    .s_pay_valid    (s_pay_valid),
    .s_pay_ready    (s_pay_ready),
    .m_hdr_ready    (m_hdr_ready),
    .m_hdr_valid    (m_hdr_valid),
    .hdr_load       (hdr_load),
    .word_sel       (word_sel),
    .hdr_word       (hdr_word),
    .last_hdr_word  (last_hdr_word),
    .shift_beat     (shift_beat),
    .shift_valid    (shift_valid),
    .shift_can_take (shift_can_take),
    .shift_take     (shift_take),
    .shift_flush    (shift_flush),
    .room           (room),
    .in_beat        (in_beat),
    .in_valid       (in_valid),
    .busy           (busy)
  );

  roce_hdr_words u_hdr (
    .clk           (clk),
    .s_req         (s_req),
    .hdr_load      (hdr_load),
    .word_sel      (word_sel),
    .m_hdr         (m_hdr),
    .hdr_word      (hdr_word),
    .has_reth      (has_reth),
    .last_hdr_word (last_hdr_word)
  );

  payload_realign u_realign (
    .clk            (clk),
    .rst            (rst),
    .s_pay          (s_pay),
    .shift_take     (shift_take),
    .shift_flush    (shift_flush),
    .shift_beat     (shift_beat),
    .shift_valid    (shift_valid),
    .shift_can_take (shift_can_take)
  );

  axis_skid u_skid (
    .clk         (clk),
    .rst         (rst),
    .in_beat     (in_beat),
    .in_valid    (in_valid),
    .room        (room),
    .m_pay       (m_pay),
    .m_pay_valid (m_pay_valid),
    .m_pay_ready (m_pay_ready)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the roce transmit testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module roce_tx_tb -f src.f -o roce_tx_sim \
    > build.log 2>&1; then
  echo "verilator build failed, see build.log"
  exit 1
fi

if ! ./obj_dir/roce_tx_sim > sim.log 2>&1; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- src.f
logic/roce_tx_pkg.sv
logic/axis_skid.sv
logic/payload_realign.sv
logic/roce_hdr_words.sv
logic/roce_tx_ctrl.sv
logic/roce_tx_top.sv
tests/roce_tx_tb.sv

//--- tests/roce_tx_tb.sv
// testbench for the roce v2 transmit header inserter
// random requests and payloads from a fixed-seed LCG, random sink
// stalls, and a byte-level model of the expected output stream
`timescale 1ns/10ps

module roce_tx_tb
  import roce_tx_pkg::*;
();

  localparam int NUM_PKTS = 60;
  localparam int CYCLES_PER_PKT = 40;
  localparam int CYCLE_LIMIT = NUM_PKTS * CYCLES_PER_PKT;

  logic       clk = 1'b0;
  logic       rst;
  tx_req_t    s_req;
  logic       s_req_valid;
  logic       s_req_ready;
  axis_beat_t s_pay;
  logic       s_pay_valid;
  logic       s_pay_ready;
  net_hdr_t   m_hdr;
  logic       m_hdr_valid;
  logic       m_hdr_ready = 1'b0;
  axis_beat_t m_pay;
  logic       m_pay_valid;
  logic       m_pay_ready = 1'b0;
  logic       busy;

  net_hdr_t    exp_hdrs[$];
  axis_beat_t  exp_beats[$];
  axis_beat_t  in_beats[$];
  int          errors = 0;
  int          beats_seen = 0;
  int          hdrs_seen = 0;
  int          cycles = 0;
  logic [31:0] stim_rng = 32'h62ac;
  logic [31:0] ready_rng = 32'h62ac;

  roce_tx_top dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(output logic [31:0] w);
    stim_rng = lcg_step(stim_rng);
    w = stim_rng;
  endtask

  // one 8-byte beat of a byte stream, byte 0 in the low lane
  function automatic axis_beat_t make_beat(input logic [7:0] bytes[$], input int start,
                                           input logic user_last);
    axis_beat_t b;
    int         n;
    b = '0;
    n = 0;
    for (int j = 0; j < 8; j++) begin
      if (start + j < bytes.size()) begin
        b.data[j*8 +: 8] = bytes[start + j];
        n++;
      end
    end
    b.keep = count_keep(4'(n));
    b.last = (start + 8 >= bytes.size());
    b.user = b.last && user_last;
    return b;
  endfunction

  task automatic check_hdr(input net_hdr_t got, input net_hdr_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: header mismatch, ip_length %h expected %h", $time,
               got.ip_length, exp.ip_length);
      $display("    got %h", got);
      $display("    exp %h", exp);
    end
  endtask

  task automatic check_beat(input axis_beat_t got, input axis_beat_t exp);
    logic [63:0] mask;
    for (int j = 0; j < 8; j++) begin
      mask[j*8 +: 8] = {8{exp.keep[j]}};
    end
    if (got.keep !== exp.keep || got.last !== exp.last || got.user !== exp.user ||
        (got.data & mask) !== (exp.data & mask)) begin
      errors++;
      $display("ERR %0t: beat data %h keep %h last %b user %b", $time,
               got.data, got.keep, got.last, got.user);
      $display("    expected data %h keep %h last %b user %b",
               exp.data & mask, exp.keep, exp.last, exp.user);
    end
  endtask

  // random request plus the expected header and output beats
  task automatic build_packet(output tx_req_t req);
    logic [639:0] bits;
    logic [31:0]  w;
    logic [7:0]   stream[$];
    logic [7:0]   pay_bytes[$];
    net_hdr_t     hdr;
    int           n_pay;
    logic         user_last;
    for (int i = 0; i < 20; i++) begin
      draw(w);
      bits[i*32 +: 32] = w;
    end
    req = tx_req_t'(bits[601:0]);
    draw(w);
    req.has_reth = w[31];
    user_last = w[30];
    n_pay = int'(w[23:16]) % 40 + 1;

    hdr = req.net;
    hdr.ip_length = req.net.udp_length + 16'd20;
    exp_hdrs.push_back(hdr);

    // BTH with zero flags and reserved bytes, ack request in the top bit of byte 8
    stream.push_back(req.bth.opcode);
    stream.push_back(8'h00);
    stream.push_back(req.bth.p_key[15:8]);
    stream.push_back(req.bth.p_key[7:0]);
    stream.push_back(8'h00);
    stream.push_back(req.bth.dest_qp[23:16]);
    stream.push_back(req.bth.dest_qp[15:8]);
    stream.push_back(req.bth.dest_qp[7:0]);
    stream.push_back({req.bth.ack_req, 7'b0});
    stream.push_back(req.bth.psn[23:16]);
    stream.push_back(req.bth.psn[15:8]);
    stream.push_back(req.bth.psn[7:0]);
    if (req.has_reth) begin
      for (int i = 7; i >= 0; i--) begin
        stream.push_back(req.reth.v_addr[i*8 +: 8]);
      end
      for (int i = 3; i >= 0; i--) begin
        stream.push_back(req.reth.r_key[i*8 +: 8]);
      end
      for (int i = 3; i >= 0; i--) begin
        stream.push_back(req.reth.dma_len[i*8 +: 8]);
      end
    end
    for (int i = 0; i < n_pay; i++) begin
      draw(w);
      pay_bytes.push_back(w[31:24]);
      stream.push_back(w[31:24]);
    end

    for (int s = 0; s < stream.size(); s += 8) begin
      exp_beats.push_back(make_beat(stream, s, user_last));
    end
    for (int s = 0; s < pay_bytes.size(); s += 8) begin
      in_beats.push_back(make_beat(pay_bytes, s, user_last));
    end
  endtask

  task automatic send_req(input tx_req_t req);
    s_req = req;
    s_req_valid = 1'b1;
    @(negedge clk);
    while (!s_req_ready) begin
      @(negedge clk);
    end
    if (m_hdr_valid) begin
      errors++;
      $display("request accepted at %0t while the previous header was still waiting", $time);
    end
    @(posedge clk);
    #1;
    s_req_valid = 1'b0;
    if (!busy) begin
      errors++;
      $display("busy low at %0t although a request was just accepted", $time);
    end
  endtask

  task automatic send_beat(input axis_beat_t beat);
    s_pay = beat;
    s_pay_valid = 1'b1;
    @(negedge clk);
    while (!s_pay_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    s_pay_valid = 1'b0;
    s_pay = '0;
  endtask

  // sink readies, changed just after each rising edge
  always @(posedge clk) begin
    #1;
    ready_rng = lcg_step(ready_rng);
    m_pay_ready = (ready_rng[31:30] != 2'b00);
    m_hdr_ready = (ready_rng[29:28] != 2'b00);
  end

  // outputs sampled mid-cycle, a transfer completes at the next edge
  always @(negedge clk) begin
    if (!rst && m_pay_valid && m_pay_ready) begin
      if (exp_beats.size() == 0) begin
        errors++;
        $display("output beat at %0t with no beat expected", $time);
      end else begin
        check_beat(m_pay, exp_beats.pop_front());
        beats_seen++;
      end
    end
    if (!rst && m_hdr_valid && m_hdr_ready) begin
      if (exp_hdrs.size() == 0) begin
        errors++;
        $display("output header at %0t with no header expected", $time);
      end else begin
        check_hdr(m_hdr, exp_hdrs.pop_front());
        hdrs_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    tx_req_t     req;
    axis_beat_t  beat;
    logic [31:0] w;
    rst = 1'b1;
    s_req = '0;
    s_req_valid = 1'b0;
    s_pay = '0;
    s_pay_valid = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    // handshakes and status all idle in reset
    if (s_req_ready || s_pay_ready || m_hdr_valid || m_pay_valid || busy) begin
      errors++;
      $display("outputs not idle during reset at %0t", $time);
    end
    rst = 1'b0;

    for (int p = 0; p < NUM_PKTS; p++) begin
      build_packet(req);
      send_req(req);
      while (in_beats.size() != 0) begin
        beat = in_beats.pop_front();
        draw(w);
        // idle gap of 0 to 3 cycles before each input beat
        repeat (int'(w[31:30])) begin
          @(posedge clk);
          #1;
        end
        send_beat(beat);
      end
    end

    while (exp_beats.size() != 0 || exp_hdrs.size() != 0 || busy) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    if (m_pay_valid || m_hdr_valid || busy) begin
      errors++;
      $display("output still active at %0t after the last expected beat", $time);
    end
    $display("errors %0d, beats checked %0d, headers checked %0d",
             errors, beats_seen, hdrs_seen);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
